// ==== verilog/rob_pkg.sv ====
// Reorder buffer shared definitions
// Sizes, tag types and the retire count encoding used by every block
// of the two-wide reorder buffer.

package rob_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////

	localparam int ROB_DEPTH = 16;     // entries in the buffer
	localparam int ROB_IDX_W = 4;      // log2 of depth
	localparam int PR_TAG_W  = 7;      // physical register tag
	localparam int AR_W      = 5;      // architectural register index
	localparam int CDB_PORTS = 6;      // result broadcast ports

	//////////////////////////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////////////////////////

	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [ROB_IDX_W:0]   rob_count_t;   // 0 to ROB_DEPTH
	typedef logic [PR_TAG_W-1:0]  pr_tag_t;
	typedef logic [AR_W-1:0]      ar_idx_t;

	// all ones, never handed out by the free list
	localparam pr_tag_t NO_TAG = '1;

	// doubles as the retire count seen by the rest of the core
	typedef enum logic [1:0]
	{
		RETIRE_NONE = 2'd0,
		RETIRE_ONE  = 2'd1,
		RETIRE_TWO  = 2'd2
	} retire_mode_t;

endpackage

// ==== verilog/rob_dispatch.sv ====
// Reorder buffer dispatch side
// Keeps the tail pointer and the occupancy count, turns the dispatch
// count into slot write strobes and reports free capacity to decode.

`timescale 1ns/1ps

module rob_dispatch
	import rob_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic [1:0]   dispatch_num,
	input  retire_mode_t retire_num,
	output logic [1:0]   dispatch_cap,
	output rob_idx_t     tail,
	output logic         write_en0,
	output logic         write_en1
);

	rob_count_t count;          // valid entries in the buffer
	rob_count_t free_slots;
	rob_count_t count_next;
	rob_idx_t   tail_next;

	//////////////////////////////////////////////////////////////////////
	// strobes and capacity
	//////////////////////////////////////////////////////////////////////

	assign write_en0 = (dispatch_num != 2'd0);   // slot 0 used for 1 or 2
	assign write_en1 = (dispatch_num == 2'd2);   // slot 1 only when 2

	assign free_slots = rob_count_t'(ROB_DEPTH) - count;

	always_comb
	begin
		if (free_slots >= rob_count_t'(2))
			dispatch_cap = 2'd2;
		else
			dispatch_cap = free_slots[1:0];          // 1 or 0 here
	end

	// dispatched minus retired, both at the same edge
	assign count_next = count + rob_count_t'(dispatch_num)
		- rob_count_t'(retire_num);

	// depth is a power of two, so the index width does the wrap
	assign tail_next = tail + rob_idx_t'(dispatch_num);

	//////////////////////////////////////////////////////////////////////
	// state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			tail  <= tail_next;
			count <= count_next;
		end
	end

	// decode must respect the capacity it was given this cycle
	assert property (@(posedge clock) disable iff (reset)
		dispatch_num <= dispatch_cap)
		else $error("dispatch of %0d with only %0d free", dispatch_num, dispatch_cap);

	assert property (@(posedge clock) disable iff (reset)
		dispatch_num != 2'd3)
		else $error("dispatch count of 3 is illegal");

endmodule

// ==== verilog/rob_entry_table.sv ====
// Reorder buffer entry storage
// Writes new entries at the tail, marks entries complete from the
// result broadcast ports, frees retired entries and presents the
// two entries at the head to the retire logic.

`timescale 1ns/1ps

module rob_entry_table
	import rob_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  rob_idx_t             tail,
	input  logic                 write_en0,
	input  logic                 write_en1,
	input  rob_idx_t             head,
	input  retire_mode_t         retire_num,
	input  pr_tag_t              pr_tag0,
	input  pr_tag_t              pr_tag1,
	input  ar_idx_t              dest_ar0,
	input  ar_idx_t              dest_ar1,
	input  logic                 valid_inst0,
	input  logic                 valid_inst1,
	input  logic                 halt0,
	input  logic                 halt1,
	input  logic                 wr_mem0,
	input  logic                 wr_mem1,
	input  logic [CDB_PORTS-1:0] cdb_valid,
	input  pr_tag_t              cdb_tag [CDB_PORTS],
	input  logic [CDB_PORTS-1:0] cdb_exception,
	output logic                 head_ready0,
	output logic                 head_ready1,
	output logic                 head_exception0,
	output logic                 head_exception1,
	output logic                 head_wr_mem0,
	output logic                 head_wr_mem1,
	output logic                 head_halt0,
	output logic                 head_halt1,
	output ar_idx_t              head_ar0,
	output ar_idx_t              head_ar1,
	output pr_tag_t              head_tag0,
	output pr_tag_t              head_tag1
);

	logic [ROB_DEPTH-1:0] entry_valid;
	logic [ROB_DEPTH-1:0] entry_ready;
	logic [ROB_DEPTH-1:0] entry_exc;
	logic [ROB_DEPTH-1:0] entry_wr_mem;
	logic [ROB_DEPTH-1:0] entry_halt;
	ar_idx_t              entry_ar  [ROB_DEPTH];
	pr_tag_t              entry_tag [ROB_DEPTH];

	logic [ROB_DEPTH-1:0] port_match [CDB_PORTS];
	logic [ROB_DEPTH-1:0] cdb_hit;
	logic [ROB_DEPTH-1:0] cdb_exc;

	rob_idx_t tail_plus_one;
	rob_idx_t head_plus_one;
	logic     free0;
	logic     free1;

	assign tail_plus_one = tail + rob_idx_t'(1);
	assign head_plus_one = head + rob_idx_t'(1);
	assign free0 = (retire_num != RETIRE_NONE);
	assign free1 = (retire_num == RETIRE_TWO);

	//////////////////////////////////////////////////////////////////////
	// result broadcast match
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int p = 0; p < CDB_PORTS; p++)
		begin
			for (int i = 0; i < ROB_DEPTH; i++)
			begin
				port_match[p][i] = cdb_valid[p] && entry_valid[i]
					&& (cdb_tag[p] == entry_tag[i]);
			end
		end
	end

	// fold the ports down to one hit and one exception per entry
	always_comb
	begin
		for (int i = 0; i < ROB_DEPTH; i++)
		begin
			cdb_hit[i] = 1'b0;
			cdb_exc[i] = 1'b0;
			for (int p = 0; p < CDB_PORTS; p++)
			begin
				if (port_match[p][i])
				begin
					cdb_hit[i] = 1'b1;
					cdb_exc[i] = cdb_exc[i] | cdb_exception[p];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			entry_valid  <= '0;
			entry_ready  <= '0;
			entry_exc    <= '0;
			entry_wr_mem <= '0;
			entry_halt   <= '0;
			for (int i = 0; i < ROB_DEPTH; i++)
				entry_tag[i] <= NO_TAG;
		end
		else
		begin
			for (int i = 0; i < ROB_DEPTH; i++)
			begin
				if (cdb_hit[i])
				begin
					entry_ready[i] <= 1'b1;
					entry_exc[i]   <= cdb_exc[i];
				end
				// retired entries drop out; never overlaps a write slot
				if ((free0 && rob_idx_t'(i) == head) || (free1 && rob_idx_t'(i) == head_plus_one))
				begin
					entry_valid[i] <= 1'b0;
					entry_ready[i] <= 1'b0;
					entry_exc[i]   <= 1'b0;
					entry_tag[i]   <= NO_TAG;
				end
				if (write_en0 && rob_idx_t'(i) == tail)
				begin
					entry_valid[i]  <= 1'b1;
					entry_ready[i]  <= halt0 | ~valid_inst0;   // nothing to wait for
					entry_exc[i]    <= 1'b0;
					entry_wr_mem[i] <= wr_mem0;
					entry_halt[i]   <= halt0;
					entry_tag[i]    <= pr_tag0;
				end
				if (write_en1 && rob_idx_t'(i) == tail_plus_one)
				begin
					entry_valid[i]  <= 1'b1;
					entry_ready[i]  <= halt1 | ~valid_inst1;
					entry_exc[i]    <= 1'b0;
					entry_wr_mem[i] <= wr_mem1;
					entry_halt[i]   <= halt1;
					entry_tag[i]    <= pr_tag1;
				end
			end
		end
	end

	// register index is payload only
	always_ff @(posedge clock)
	begin
		if (write_en0)
			entry_ar[tail] <= dest_ar0;
		if (write_en1)
			entry_ar[tail_plus_one] <= dest_ar1;
	end

	//////////////////////////////////////////////////////////////////////
	// head pair view
	//////////////////////////////////////////////////////////////////////

	assign head_ready0     = entry_ready[head];
	assign head_ready1     = entry_ready[head_plus_one];
	assign head_exception0 = entry_exc[head];
	assign head_exception1 = entry_exc[head_plus_one];
	assign head_wr_mem0    = entry_wr_mem[head];
	assign head_wr_mem1    = entry_wr_mem[head_plus_one];
	assign head_halt0      = entry_halt[head];
	assign head_halt1      = entry_halt[head_plus_one];
	assign head_ar0        = entry_ar[head];
	assign head_ar1        = entry_ar[head_plus_one];
	assign head_tag0       = entry_tag[head];
	assign head_tag1       = entry_tag[head_plus_one];

	// the free list must never hand out a tag that is still in flight
	for (genvar p = 0; p < CDB_PORTS; p++)
	begin : g_match_chk
		assert property (@(posedge clock) disable iff (reset)
			$onehot0(port_match[p]))
			else $error("broadcast port %0d tag hits several entries", p);
	end

endmodule

// ==== verilog/rob_retire.sv ====
// Reorder buffer retire side
// Applies the two-wide in-order retire rule to the head pair, drives
// the retire outputs and advances the head pointer.

`timescale 1ns/1ps

module rob_retire
	import rob_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         head_ready0,
	input  logic         head_ready1,
	input  logic         head_exception0,
	input  logic         head_exception1,
	input  logic         head_wr_mem0,
	input  logic         head_wr_mem1,
	input  logic         head_halt0,
	input  logic         head_halt1,
	input  ar_idx_t      head_ar0,
	input  ar_idx_t      head_ar1,
	input  pr_tag_t      head_tag0,
	input  pr_tag_t      head_tag1,
	output rob_idx_t     head,
	output retire_mode_t retire_num,
	output ar_idx_t      retire_ar_a,
	output ar_idx_t      retire_ar_b,
	output pr_tag_t      retire_tag_a,
	output pr_tag_t      retire_tag_b,
	output logic         retire_wr_mem_a,
	output logic         retire_wr_mem_b,
	output logic         retire_exception,
	output logic         retire_halt
);

	logic pair_ok;      // second entry may go with the first
	logic take0;
	logic take1;

	//////////////////////////////////////////////////////////////////////
	// retire rule
	//////////////////////////////////////////////////////////////////////

	// only one store per cycle toward the store queue
	assign pair_ok = head_ready1 & ~head_exception0 & ~(head_wr_mem0 & head_wr_mem1);

	always_comb
	begin
		if (head_ready0 && pair_ok)
			retire_num = RETIRE_TWO;
		else if (head_ready0)
			retire_num = RETIRE_ONE;
		else
			retire_num = RETIRE_NONE;
	end

	assign take0 = (retire_num != RETIRE_NONE);
	assign take1 = (retire_num == RETIRE_TWO);

	assign retire_ar_a     = head_ar0;
	assign retire_ar_b     = head_ar1;
	assign retire_tag_a    = head_tag0;
	assign retire_tag_b    = head_tag1;
	assign retire_wr_mem_a = head_wr_mem0 & take0;   // qualified for the store queue
	assign retire_wr_mem_b = head_wr_mem1 & take1;

	assign retire_exception = (take0 & head_exception0) | (take1 & head_exception1);
	assign retire_halt      = (take0 & head_halt0) | (take1 & head_halt1);

	//////////////////////////////////////////////////////////////////////
	// head pointer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else
			head <= head + rob_idx_t'(retire_num);   // wraps at depth
	end

endmodule

// ==== verilog/rob_top.sv ====
// Two-wide reorder buffer
// Connects dispatch, entry storage and retire into one block with
// loose dispatch, broadcast and retire ports.

`timescale 1ns/1ps

module rob_top
	import rob_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [1:0]           dispatch_num,
	input  pr_tag_t              pr_tag0,
	input  pr_tag_t              pr_tag1,
	input  ar_idx_t              dest_ar0,
	input  ar_idx_t              dest_ar1,
	input  logic                 valid_inst0,
	input  logic                 valid_inst1,
	input  logic                 halt0,
	input  logic                 halt1,
	input  logic                 wr_mem0,
	input  logic                 wr_mem1,
	input  logic [CDB_PORTS-1:0] cdb_valid,
	input  pr_tag_t              cdb_tag [CDB_PORTS],
	input  logic [CDB_PORTS-1:0] cdb_exception,
	output logic [1:0]           dispatch_cap,
	output retire_mode_t         retire_num,
	output ar_idx_t              retire_ar_a,
	output ar_idx_t              retire_ar_b,
	output pr_tag_t              retire_tag_a,
	output pr_tag_t              retire_tag_b,
	output logic                 retire_wr_mem_a,
	output logic                 retire_wr_mem_b,
	output logic                 retire_exception,
	output logic                 retire_halt
);

	rob_idx_t tail;
	rob_idx_t head;
	logic     write_en0;
	logic     write_en1;

	// head pair from storage to retire
	logic    head_ready0;
	logic    head_ready1;
	logic    head_exception0;
	logic    head_exception1;
	logic    head_wr_mem0;
	logic    head_wr_mem1;
	logic    head_halt0;
	logic    head_halt1;
	ar_idx_t head_ar0;
	ar_idx_t head_ar1;
	pr_tag_t head_tag0;
	pr_tag_t head_tag1;

	rob_dispatch u_dispatch
	(
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.retire_num   (retire_num),
		.dispatch_cap (dispatch_cap),
		.tail         (tail),
		.write_en0    (write_en0),
		.write_en1    (write_en1)
	);

	rob_entry_table u_entry_table
	(
		.clock           (clock),
		.reset           (reset),
		.tail            (tail),
		.write_en0       (write_en0),
		.write_en1       (write_en1),
		.head            (head),
		.retire_num      (retire_num),
		.pr_tag0         (pr_tag0),
		.pr_tag1         (pr_tag1),
		.dest_ar0        (dest_ar0),
		.dest_ar1        (dest_ar1),
		.valid_inst0     (valid_inst0),
		.valid_inst1     (valid_inst1),
		.halt0           (halt0),
		.halt1           (halt1),
		.wr_mem0         (wr_mem0),
		.wr_mem1         (wr_mem1),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.cdb_exception   (cdb_exception),
		.head_ready0     (head_ready0),
		.head_ready1     (head_ready1),
		.head_exception0 (head_exception0),
		.head_exception1 (head_exception1),
		.head_wr_mem0    (head_wr_mem0),
		.head_wr_mem1    (head_wr_mem1),
		.head_halt0      (head_halt0),
		.head_halt1      (head_halt1),
		.head_ar0        (head_ar0),
		.head_ar1        (head_ar1),
		.head_tag0       (head_tag0),
		.head_tag1       (head_tag1)
	);

	rob_retire u_retire
	(
		.clock            (clock),
		.reset            (reset),
		.head_ready0      (head_ready0),
		.head_ready1      (head_ready1),
		.head_exception0  (head_exception0),
		.head_exception1  (head_exception1),
		.head_wr_mem0     (head_wr_mem0),
		.head_wr_mem1     (head_wr_mem1),
		.head_halt0       (head_halt0),
		.head_halt1       (head_halt1),
		.head_ar0         (head_ar0),
		.head_ar1         (head_ar1),
		.head_tag0        (head_tag0),
		.head_tag1        (head_tag1),
		.head             (head),
		.retire_num       (retire_num),
		.retire_ar_a      (retire_ar_a),
		.retire_ar_b      (retire_ar_b),
		.retire_tag_a     (retire_tag_a),
		.retire_tag_b     (retire_tag_b),
		.retire_wr_mem_a  (retire_wr_mem_a),
		.retire_wr_mem_b  (retire_wr_mem_b),
		.retire_exception (retire_exception),
		.retire_halt      (retire_halt)
	);

endmodule

// ==== verif/rob_tb.sv ====
// Reorder buffer testbench
// Drives dispatch and result broadcast traffic into the two-wide reorder
// buffer and checks every retirement against an in-order model queue.

`timescale 1ns/1ps

module rob_tb
	import rob_pkg::*;
();

	localparam int WAIT_LIMIT     = 200;   // cycles per wait loop
	localparam int KIND_PLAIN     = 0;
	localparam int KIND_STORE     = 1;     // half of them stores
	localparam int KIND_ALL_STORE = 2;
	localparam int KIND_EXC       = 3;     // some raise an exception
	localparam int KIND_HALT      = 4;     // halts and invalids mixed in
	localparam int KIND_QUIET     = 5;     // only halts and invalids

	logic                 clock;
	logic                 reset;
	logic [1:0]           dispatch_num;
	pr_tag_t              pr_tag0;
	pr_tag_t              pr_tag1;
	ar_idx_t              dest_ar0;
	ar_idx_t              dest_ar1;
	logic                 valid_inst0;
	logic                 valid_inst1;
	logic                 halt0;
	logic                 halt1;
	logic                 wr_mem0;
	logic                 wr_mem1;
	logic [CDB_PORTS-1:0] cdb_valid;
	pr_tag_t              cdb_tag [CDB_PORTS];
	logic [CDB_PORTS-1:0] cdb_exception;
	logic [1:0]           dispatch_cap;
	retire_mode_t         retire_num;
	ar_idx_t              retire_ar_a;
	ar_idx_t              retire_ar_b;
	pr_tag_t              retire_tag_a;
	pr_tag_t              retire_tag_b;
	logic                 retire_wr_mem_a;
	logic                 retire_wr_mem_b;
	logic                 retire_exception;
	logic                 retire_halt;

	// model queue, one entry per dispatched instruction
	pr_tag_t model_tag [$];
	ar_idx_t model_ar [$];
	logic    model_store [$];
	logic    model_halt [$];
	logic    model_exc [$];
	pr_tag_t pending [$];          // tags still waiting for a broadcast
	logic    exc_plan [128];       // exception to raise per tag
	pr_tag_t next_tag;

	// expected values, set mid-cycle and sampled at the next rising edge
	int         occ;
	logic [1:0] exp_cap;
	logic       model_empty;
	logic       chk_active;
	logic       chk_two;
	pr_tag_t    exp_tag_a;
	pr_tag_t    exp_tag_b;
	ar_idx_t    exp_ar_a;
	ar_idx_t    exp_ar_b;
	logic [1:0] exp_wr;            // {b, a}
	logic       exp_exc;
	logic       exp_halt;
	logic       exp_both_store;
	logic       exp_first_exc;
	logic       st_a;
	logic       st_b;
	logic       ex_a;
	logic       ex_b;
	logic       hl_a;
	logic       hl_b;

	string test_name;
	int    errors;
	int    errors_at_start;
	int    tests;
	int    failed;

	rob_top DUT (.*);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////////////

	task automatic value_error(input string what, input int expected, input int actual);
		$display("** Error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
		errors = errors + 1;
	endtask

	task automatic note_failure(input string msg);
		$display("%s in test %s", msg, test_name);
		errors = errors + 1;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests = tests + 1;
		if (errors != errors_at_start)
		begin
			failed = failed + 1;
			$display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
		end
		else
			$display("test %s: passed", test_name);
	endtask

	////////////////////////////////////////////////////////////////////
	// model
	////////////////////////////////////////////////////////////////////

	task automatic record(input pr_tag_t tag, input ar_idx_t ar, input logic st,
		input logic hl, input logic vi);
		model_tag.push_back(tag);
		model_ar.push_back(ar);
		model_store.push_back(st);
		model_halt.push_back(hl);
		model_exc.push_back(vi && !hl && exc_plan[tag]);   // no broadcast, no exception
	endtask

	// inputs were driven half a cycle ago, so they are stable here
	always @(posedge clock)
	begin
		if (!reset && dispatch_num != 2'd0)
			record(pr_tag0, dest_ar0, wr_mem0, halt0, valid_inst0);
		if (!reset && dispatch_num == 2'd2)
			record(pr_tag1, dest_ar1, wr_mem1, halt1, valid_inst1);
	end

	// retire outputs only depend on registered state
	always @(negedge clock)
	begin
		occ = model_tag.size();
		exp_cap = (occ >= ROB_DEPTH - 1) ? 2'(ROB_DEPTH - occ) : 2'd2;
		model_empty = (occ == 0);
		chk_active = (retire_num != RETIRE_NONE);
		chk_two = (retire_num == RETIRE_TWO);
		st_b = 1'b0;
		ex_b = 1'b0;
		hl_b = 1'b0;
		if ((chk_two && occ < 2) || (chk_active && occ < 1))
		begin
			note_failure("retirement with no matching dispatched instruction");
			chk_active = 1'b0;
			chk_two = 1'b0;
		end
		else if (chk_active)
		begin
			exp_tag_a = model_tag.pop_front();
			exp_ar_a = model_ar.pop_front();
			st_a = model_store.pop_front();
			hl_a = model_halt.pop_front();
			ex_a = model_exc.pop_front();
			if (chk_two)
			begin
				exp_tag_b = model_tag.pop_front();
				exp_ar_b = model_ar.pop_front();
				st_b = model_store.pop_front();
				hl_b = model_halt.pop_front();
				ex_b = model_exc.pop_front();
			end
			exp_wr = {st_b, st_a};
			exp_exc = ex_a | ex_b;
			exp_halt = hl_a | hl_b;
			exp_both_store = st_a & st_b;
			exp_first_exc = ex_a;
		end
	end

	////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////

	a_cap: assert property (@(posedge clock) disable iff (reset) dispatch_cap == exp_cap)
		else value_error("dispatch_cap", int'(exp_cap), int'(dispatch_cap));
	a_idle: assert property (@(posedge clock) disable iff (reset)
		model_empty |-> retire_num == RETIRE_NONE && !retire_exception && !retire_halt)
		else note_failure("retire outputs active with an empty buffer");
	a_tag_a: assert property (@(posedge clock) disable iff (reset)
		chk_active |-> retire_tag_a == exp_tag_a)
		else value_error("retire_tag_a", int'(exp_tag_a), int'(retire_tag_a));
	a_ar_a: assert property (@(posedge clock) disable iff (reset)
		chk_active |-> retire_ar_a == exp_ar_a)
		else value_error("retire_ar_a", int'(exp_ar_a), int'(retire_ar_a));
	a_tag_b: assert property (@(posedge clock) disable iff (reset)
		chk_two |-> retire_tag_b == exp_tag_b)
		else value_error("retire_tag_b", int'(exp_tag_b), int'(retire_tag_b));
	a_ar_b: assert property (@(posedge clock) disable iff (reset)
		chk_two |-> retire_ar_b == exp_ar_b)
		else value_error("retire_ar_b", int'(exp_ar_b), int'(retire_ar_b));
	a_pair_store: assert property (@(posedge clock) disable iff (reset)
		chk_two |-> !exp_both_store)
		else note_failure("two stores retired in the same cycle");
	a_pair_exc: assert property (@(posedge clock) disable iff (reset)
		chk_two |-> !exp_first_exc)
		else note_failure("a second entry retired behind an exception");
	a_wr: assert property (@(posedge clock) disable iff (reset)
		chk_active |-> {retire_wr_mem_b, retire_wr_mem_a} == exp_wr)
		else value_error("retire_wr_mem b/a", int'(exp_wr),
			int'({retire_wr_mem_b, retire_wr_mem_a}));
	a_exc: assert property (@(posedge clock) disable iff (reset)
		chk_active |-> retire_exception == exp_exc)
		else value_error("retire_exception", int'(exp_exc), int'(retire_exception));
	a_halt: assert property (@(posedge clock) disable iff (reset)
		chk_active |-> retire_halt == exp_halt)
		else value_error("retire_halt", int'(exp_halt), int'(retire_halt));

	////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////

	task automatic make_inst(input int kind, input int slot);
		pr_tag_t tag;
		ar_idx_t ar;
		logic    st;
		logic    hl;
		logic    vi;
		logic    ex;
		int      pick;
		tag = next_tag;
		next_tag = (next_tag == 7'd126) ? 7'd0 : next_tag + 7'd1;   // skip NO_TAG
		ar = ar_idx_t'($urandom);
		pick = int'($urandom_range(3, 0));
		st = 1'b0;
		hl = 1'b0;
		vi = 1'b1;
		ex = 1'b0;
		case (kind)
			KIND_STORE:     st = (pick < 2);
			KIND_ALL_STORE: st = 1'b1;
			KIND_EXC:
			begin
				ex = (pick == 0);
				st = (pick == 3);
			end
			KIND_HALT:
			begin
				hl = (pick == 0);
				vi = (pick != 1);
			end
			KIND_QUIET:
			begin
				hl = (pick < 2);
				vi = (pick < 2);
			end
			default: st = 1'b0;
		endcase
		exc_plan[tag] = ex;
		if (vi && !hl)
			pending.push_back(tag);
		if (slot == 0)
		begin
			pr_tag0 = tag;
			dest_ar0 = ar;
			wr_mem0 = st;
			halt0 = hl;
			valid_inst0 = vi;
		end
		else
		begin
			pr_tag1 = tag;
			dest_ar1 = ar;
			wr_mem1 = st;
			halt1 = hl;
			valid_inst1 = vi;
		end
	endtask

	task automatic issue(input int n, input int kind, input int max_group);
		int left;
		int grp;
		int waited;
		left = n;
		while (left > 0)
		begin
			@(negedge clock);
			dispatch_num = 2'd0;
			waited = 0;
			while (dispatch_cap == 2'd0 && waited < WAIT_LIMIT)
			begin
				@(negedge clock);
				waited = waited + 1;
			end
			if (dispatch_cap == 2'd0)
			begin
				note_failure("timeout waiting for dispatch capacity");
				left = 0;
			end
			else
			begin
				grp = 1;
				if (max_group == 2 && left >= 2 && dispatch_cap == 2'd2 && $urandom_range(1, 0) == 1)
					grp = 2;
				make_inst(kind, 0);
				if (grp == 2)
					make_inst(kind, 1);
				dispatch_num = 2'(grp);
				left = left - grp;
			end
		end
		@(negedge clock);
		dispatch_num = 2'd0;
	endtask

	// random order, random ports, up to max_k broadcasts per cycle
	task automatic complete_all(input int max_k);
		int k;
		int base;
		int idx;
		int port;
		pr_tag_t tag;
		while (pending.size() > 0)
		begin
			@(negedge clock);
			cdb_valid = '0;
			cdb_exception = '0;
			k = int'($urandom_range(max_k, 1));
			if (k > pending.size())
				k = pending.size();
			base = int'($urandom_range(CDB_PORTS - 1, 0));
			for (int j = 0; j < k; j++)
			begin
				idx = int'($urandom_range(pending.size() - 1, 0));
				tag = pending[idx];
				pending.delete(idx);
				port = (base + j) % CDB_PORTS;
				cdb_valid[port] = 1'b1;
				cdb_tag[port] = tag;
				cdb_exception[port] = exc_plan[tag];
			end
		end
		@(negedge clock);
		cdb_valid = '0;
		cdb_exception = '0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (model_tag.size() != 0 && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited = waited + 1;
		end
		if (model_tag.size() != 0)
			note_failure("timeout waiting for the buffer to drain");
		@(negedge clock);
	endtask

	task automatic run_batch(input int n, input int kind, input int max_group, input int max_k);
		issue(n, kind, max_group);
		complete_all(max_k);
		drain();
	endtask

	initial
	begin
		void'($urandom(32'h1e5b));
		clock = 1'b0;
		reset = 1'b1;
		dispatch_num = 2'd0;
		pr_tag0 = NO_TAG;
		pr_tag1 = NO_TAG;
		dest_ar0 = '0;
		dest_ar1 = '0;
		valid_inst0 = 1'b0;
		valid_inst1 = 1'b0;
		halt0 = 1'b0;
		halt1 = 1'b0;
		wr_mem0 = 1'b0;
		wr_mem1 = 1'b0;
		cdb_valid = '0;
		cdb_exception = '0;
		for (int p = 0; p < CDB_PORTS; p++)
			cdb_tag[p] = NO_TAG;
		for (int t = 0; t < 128; t++)
			exc_plan[t] = 1'b0;
		next_tag = '0;
		errors = 0;
		tests = 0;
		failed = 0;
		test_name = "reset_state";
		errors_at_start = 0;
		for (int i = 0; i < 10; i++)
			@(negedge clock);
		reset = 1'b0;

		begin_test("reset_state");
		for (int i = 0; i < 4; i++)
			@(negedge clock);
		end_test();

		begin_test("in_order");
		run_batch(16, KIND_PLAIN, 2, 3);
		run_batch(16, KIND_PLAIN, 2, 3);
		run_batch(8, KIND_PLAIN, 2, 3);
		end_test();

		begin_test("store_pairing");
		run_batch(8, KIND_ALL_STORE, 2, 6);   // whole groups complete at once
		run_batch(16, KIND_STORE, 2, 3);
		end_test();

		begin_test("exceptions");
		run_batch(16, KIND_EXC, 2, 3);
		run_batch(16, KIND_EXC, 2, 6);
		end_test();

		begin_test("capacity");
		issue(16, KIND_PLAIN, 1);              // one at a time through 15 and 16
		@(negedge clock);
		@(negedge clock);
		complete_all(3);
		drain();
		end_test();

		begin_test("halt_invalid");
		run_batch(10, KIND_QUIET, 2, 3);
		run_batch(16, KIND_HALT, 2, 3);
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== vlog.f ====
verilog/rob_pkg.sv
verilog/rob_dispatch.sv
verilog/rob_entry_table.sv
verilog/rob_retire.sv
verilog/rob_top.sv
verif/rob_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps
TOP       = rob_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
